// ==== common/rv_shell_defines.svh ====
/*
 * Width, region count and synchroniser depth macros
 */
`ifndef RV_SHELL_DEFINES_SVH
`define RV_SHELL_DEFINES_SVH

// Address and data word width
`define RV_SHELL_ADDR_W 32

// Remap regions on each bus
`define RV_SHELL_NUM_REGIONS 2

// Register bus byte offset width
`define RV_SHELL_REG_AW 8

// Flops in each input synchroniser
`define RV_SHELL_SYNC_STAGES 2

`endif

// ==== common/rv_shell_pkg.sv ====
/*
 * Address word type, multibit enable, register offsets, error bits
 */
`default_nettype none
`include "rv_shell_defines.svh"

package rv_shell_pkg;

  typedef logic [`RV_SHELL_ADDR_W-1:0] addr_t;

  // Only ON enables; every other code reads as off
  typedef enum logic [3:0] {
    MUBI_ON  = 4'b1010,
    MUBI_OFF = 4'b0101
  } mubi_e;

  typedef enum logic [`RV_SHELL_REG_AW-1:0] {
    REG_NMI_ENABLE  = 8'h00,
    REG_NMI_STATE   = 8'h04,
    REG_ERR_STATUS  = 8'h08,
    REG_RND_DATA    = 8'h0C,
    REG_RND_STATUS  = 8'h10,
    REG_IBUS_EN     = 8'h14,
    REG_DBUS_EN     = 8'h18,
    REG_IBUS_MATCH0 = 8'h40,
    REG_IBUS_MATCH1 = 8'h44,
    REG_IBUS_REMAP0 = 8'h60,
    REG_IBUS_REMAP1 = 8'h64,
    REG_DBUS_MATCH0 = 8'h80,
    REG_DBUS_MATCH1 = 8'h84,
    REG_DBUS_REMAP0 = 8'hA0,
    REG_DBUS_REMAP1 = 8'hA4
  } reg_addr_e;

  // Bit positions in ERR_STATUS
  typedef enum logic [1:0] {
    ERR_FATAL_INTG = 2'd0,
    ERR_FATAL_CORE = 2'd1,
    ERR_RECOV_CORE = 2'd2
  } err_bit_e;

endpackage

`default_nettype wire

// ==== rtl/addr_remap.sv ====
/*
 * Region matcher and address rewriter for one bus
 */
`timescale 1ns/1ps
`default_nettype none
`include "rv_shell_defines.svh"

module addr_remap (
  input  rv_shell_pkg::addr_t                             addr_i,
  input  logic [`RV_SHELL_NUM_REGIONS-1:0]                region_en_i,
  input  rv_shell_pkg::addr_t [`RV_SHELL_NUM_REGIONS-1:0] region_match_i,
  input  rv_shell_pkg::addr_t [`RV_SHELL_NUM_REGIONS-1:0] region_remap_i,
  output rv_shell_pkg::addr_t                             addr_o
);
  import rv_shell_pkg::*;

  localparam int unsigned NumRegions = `RV_SHELL_NUM_REGIONS;

  addr_t [NumRegions-1:0] offset_mask;
  logic  [NumRegions-1:0] region_hit;

  for (genvar i = 0; i < NumRegions; i++) begin : gen_region
    // Trailing ones of match plus the next bit form the offset
    assign offset_mask[i] = region_match_i[i] ^ (region_match_i[i] + 1'b1);
    assign region_hit[i]  = region_en_i[i] &&
        (((addr_i ^ region_match_i[i]) & ~offset_mask[i]) == '0);
  end

  // Scan downwards so the lowest hit is applied last
  always_comb begin
    addr_o = addr_i;
    for (int i = NumRegions - 1; i >= 0; i--) begin
      if (region_hit[i]) begin
        addr_o = (region_remap_i[i] & ~offset_mask[i]) | (addr_i & offset_mask[i]);
      end
    end
  end

  a_no_region_passthru: assert final (region_en_i != '0 || addr_o == addr_i)
    else $error("address rewritten with every region disabled");

endmodule

`default_nettype wire

// ==== cfg_regs/cfg_regs.sv ====
/*
 * Software registers: region config, NMI state and enable,
 * error status, entropy readout and the read mux
 */
`timescale 1ns/1ps
`default_nettype none
`include "rv_shell_defines.svh"

module cfg_regs (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            reg_we_i,
  input  logic                                            reg_re_i,
  input  logic [`RV_SHELL_REG_AW-1:0]                     reg_addr_i,
  input  rv_shell_pkg::addr_t                             reg_wdata_i,
  input  logic                                            nmi_wdog_i,
  input  logic                                            nmi_esc_i,
  input  logic                                            fatal_intg_i,
  input  logic                                            fatal_core_i,
  input  logic                                            recov_core_i,
  input  rv_shell_pkg::addr_t                             rnd_data_i,
  input  logic                                            rnd_valid_i,
  input  logic                                            rnd_fips_i,
  output rv_shell_pkg::addr_t                             reg_rdata_o,
  output logic [`RV_SHELL_NUM_REGIONS-1:0]                ibus_en_o,
  output rv_shell_pkg::addr_t [`RV_SHELL_NUM_REGIONS-1:0] ibus_match_o,
  output rv_shell_pkg::addr_t [`RV_SHELL_NUM_REGIONS-1:0] ibus_remap_o,
  output logic [`RV_SHELL_NUM_REGIONS-1:0]                dbus_en_o,
  output rv_shell_pkg::addr_t [`RV_SHELL_NUM_REGIONS-1:0] dbus_match_o,
  output rv_shell_pkg::addr_t [`RV_SHELL_NUM_REGIONS-1:0] dbus_remap_o,
  output logic                                            irq_nm_o,
  output logic                                            rnd_clear_o
);
  import rv_shell_pkg::*;

  localparam int unsigned NumRegions = `RV_SHELL_NUM_REGIONS;
  localparam int unsigned SyncStages = `RV_SHELL_SYNC_STAGES;

  reg_addr_e              reg_addr;
  logic [SyncStages-1:0]  esc_sync_q;
  logic [SyncStages-1:0]  wdog_sync_q;
  logic [1:0]             nmi_enable_q;
  logic [1:0]             nmi_state_q;
  logic [1:0]             nmi_set;
  logic [1:0]             nmi_clr;
  logic [2:0]             err_status_q;
  logic [2:0]             err_set;
  logic [2:0]             err_clr;
  logic [NumRegions-1:0]  ibus_en_q;
  logic [NumRegions-1:0]  dbus_en_q;
  addr_t [NumRegions-1:0] ibus_match_q;
  addr_t [NumRegions-1:0] ibus_remap_q;
  addr_t [NumRegions-1:0] dbus_match_q;
  addr_t [NumRegions-1:0] dbus_remap_q;

  assign reg_addr = reg_addr_e'(reg_addr_i);

  //////////////////////////////////////////////////////////////////////
  // NMI synchronisers and sticky state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      esc_sync_q  <= '0;
      wdog_sync_q <= '0;
    end else begin
      esc_sync_q  <= {esc_sync_q[SyncStages-2:0], nmi_esc_i};
      wdog_sync_q <= {wdog_sync_q[SyncStages-2:0], nmi_wdog_i};
    end
  end

  // Bit 0 escalation, bit 1 watchdog
  assign nmi_set  = {wdog_sync_q[SyncStages-1], esc_sync_q[SyncStages-1]};
  assign nmi_clr  = (reg_we_i && reg_addr == REG_NMI_STATE) ? reg_wdata_i[1:0] : 2'b00;
  assign irq_nm_o = |(nmi_state_q & nmi_enable_q);

  assign err_set[ERR_FATAL_INTG] = fatal_intg_i;
  assign err_set[ERR_FATAL_CORE] = fatal_core_i;
  assign err_set[ERR_RECOV_CORE] = recov_core_i;
  assign err_clr = (reg_we_i && reg_addr == REG_ERR_STATUS) ? reg_wdata_i[2:0] : 3'b000;

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nmi_enable_q <= '0;
      nmi_state_q  <= '0;
      err_status_q <= '0;
      ibus_en_q    <= '0;
      dbus_en_q    <= '0;
      ibus_match_q <= '0;
      ibus_remap_q <= '0;
      dbus_match_q <= '0;
      dbus_remap_q <= '0;
    end else begin
      // Hardware set beats a same-cycle clear
      nmi_state_q  <= (nmi_state_q & ~nmi_clr) | nmi_set;
      err_status_q <= (err_status_q & ~err_clr) | err_set;
      if (reg_we_i) begin
        case (reg_addr)
          REG_NMI_ENABLE:                   nmi_enable_q <= reg_wdata_i[1:0];
          REG_IBUS_EN:                      ibus_en_q <= reg_wdata_i[NumRegions-1:0];
          REG_DBUS_EN:                      dbus_en_q <= reg_wdata_i[NumRegions-1:0];
          REG_IBUS_MATCH0, REG_IBUS_MATCH1: ibus_match_q[reg_addr_i[2]] <= reg_wdata_i;
          REG_IBUS_REMAP0, REG_IBUS_REMAP1: ibus_remap_q[reg_addr_i[2]] <= reg_wdata_i;
          REG_DBUS_MATCH0, REG_DBUS_MATCH1: dbus_match_q[reg_addr_i[2]] <= reg_wdata_i;
          REG_DBUS_REMAP0, REG_DBUS_REMAP1: dbus_remap_q[reg_addr_i[2]] <= reg_wdata_i;
          default: ;
        endcase
      end
    end
  end

  assign ibus_en_o    = ibus_en_q;
  assign ibus_match_o = ibus_match_q;
  assign ibus_remap_o = ibus_remap_q;
  assign dbus_en_o    = dbus_en_q;
  assign dbus_match_o = dbus_match_q;
  assign dbus_remap_o = dbus_remap_q;

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    reg_rdata_o = '0;
    if (reg_re_i) begin
      case (reg_addr)
        REG_NMI_ENABLE:                   reg_rdata_o[1:0] = nmi_enable_q;
        REG_NMI_STATE:                    reg_rdata_o[1:0] = nmi_state_q;
        REG_ERR_STATUS:                   reg_rdata_o[2:0] = err_status_q;
        REG_RND_DATA:                     reg_rdata_o = rnd_data_i;
        REG_RND_STATUS:                   reg_rdata_o[1:0] = {rnd_fips_i, rnd_valid_i};
        REG_IBUS_EN:                      reg_rdata_o[NumRegions-1:0] = ibus_en_q;
        REG_DBUS_EN:                      reg_rdata_o[NumRegions-1:0] = dbus_en_q;
        REG_IBUS_MATCH0, REG_IBUS_MATCH1: reg_rdata_o = ibus_match_q[reg_addr_i[2]];
        REG_IBUS_REMAP0, REG_IBUS_REMAP1: reg_rdata_o = ibus_remap_q[reg_addr_i[2]];
        REG_DBUS_MATCH0, REG_DBUS_MATCH1: reg_rdata_o = dbus_match_q[reg_addr_i[2]];
        REG_DBUS_REMAP0, REG_DBUS_REMAP1: reg_rdata_o = dbus_remap_q[reg_addr_i[2]];
        default: ;
      endcase
    end
  end

  // Reading the entropy word empties the buffer
  assign rnd_clear_o = reg_re_i && (reg_addr == REG_RND_DATA);

  a_bus_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(reg_we_i && reg_re_i));

endmodule

`default_nettype wire

// ==== rtl/cpu_enable_ctrl.sv ====
/*
 * Enable synchronisers, fatal latch, fetch-enable gate, sleep register
 */
`timescale 1ns/1ps
`default_nettype none
`include "rv_shell_defines.svh"

module cpu_enable_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  rv_shell_pkg::mubi_e lc_cpu_en_i,
  input  rv_shell_pkg::mubi_e pwrmgr_cpu_en_i,
  input  logic                fatal_core_i,
  input  logic                core_sleep_i,
  output logic                fetch_enable_o,
  output logic                core_sleeping_o
);
  import rv_shell_pkg::*;

  localparam int unsigned SyncStages = `RV_SHELL_SYNC_STAGES;

  mubi_e lc_sync_q [SyncStages];
  mubi_e pwr_sync_q [SyncStages];
  mubi_e local_en_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lc_sync_q  <= '{default: MUBI_OFF};
      pwr_sync_q <= '{default: MUBI_OFF};
    end else begin
      lc_sync_q[0]  <= lc_cpu_en_i;
      pwr_sync_q[0] <= pwrmgr_cpu_en_i;
      for (int i = 1; i < SyncStages; i++) begin
        lc_sync_q[i]  <= lc_sync_q[i-1];
        pwr_sync_q[i] <= pwr_sync_q[i-1];
      end
    end
  end

  // Local enable drops for good once a fatal core error is seen
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      local_en_q      <= MUBI_ON;
      core_sleeping_o <= 1'b0;
    end else begin
      if (fatal_core_i) begin
        local_en_q <= MUBI_OFF;
      end
      core_sleeping_o <= core_sleep_i;
    end
  end

  // Strict test: all three must be exactly ON
  assign fetch_enable_o = (lc_sync_q[SyncStages-1] == MUBI_ON) &&
                          (pwr_sync_q[SyncStages-1] == MUBI_ON) &&
                          (local_en_q == MUBI_ON);

  a_fatal_stops_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fatal_core_i |=> !fetch_enable_o);

  a_off_input_stops_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lc_cpu_en_i != MUBI_ON || pwrmgr_cpu_en_i != MUBI_ON) |-> ##2 !fetch_enable_o);

endmodule

`default_nettype wire

// ==== rtl/fault_tracker.sv ====
/*
 * Core error grouping and previous-exception crash dump
 */
`timescale 1ns/1ps
`default_nettype none

module fault_tracker (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                alert_minor_i,
  input  logic                alert_major_internal_i,
  input  logic                alert_major_bus_i,
  input  logic                double_fault_i,
  input  rv_shell_pkg::addr_t exc_pc_i,
  input  rv_shell_pkg::addr_t exc_addr_i,
  output logic                fatal_intg_o,
  output logic                fatal_core_o,
  output logic                recov_core_o,
  output logic                prev_valid_o,
  output rv_shell_pkg::addr_t prev_exc_pc_o,
  output rv_shell_pkg::addr_t prev_exc_addr_o
);

  // Event classes for ERR_STATUS and the fetch latch
  assign fatal_intg_o = alert_major_bus_i;
  assign fatal_core_o = alert_major_internal_i | double_fault_i;
  assign recov_core_o = alert_minor_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_valid_o <= 1'b0;
    end else if (double_fault_i) begin
      prev_valid_o <= 1'b1;
    end
  end

  // Crash dump, a later double fault overwrites it
  always_ff @(posedge clk_i) begin
    if (double_fault_i) begin
      prev_exc_pc_o   <= exc_pc_i;
      prev_exc_addr_o <= exc_addr_i;
    end
  end

  a_dump_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    double_fault_i |=> prev_valid_o);

endmodule

`default_nettype wire

// ==== rtl/rnd_buffer.sv ====
/*
 * Entropy request and 32-bit hold buffer with clear on read
 */
`timescale 1ns/1ps
`default_nettype none

module rnd_buffer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rnd_clear_i,
  input  logic                ent_ack_i,
  input  rv_shell_pkg::addr_t ent_data_i,
  input  logic                ent_fips_i,
  output logic                ent_req_o,
  output rv_shell_pkg::addr_t rnd_data_o,
  output logic                rnd_valid_o,
  output logic                rnd_fips_o
);

  // Software read wins over a same-cycle ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rnd_valid_o <= 1'b0;
      rnd_data_o  <= '0;
      rnd_fips_o  <= 1'b0;
    end else if (rnd_clear_i) begin
      rnd_valid_o <= 1'b0;
      rnd_data_o  <= '0;
      rnd_fips_o  <= 1'b0;
    end else if (ent_ack_i && ent_req_o) begin
      rnd_valid_o <= 1'b1;
      rnd_data_o  <= ent_data_i;
      rnd_fips_o  <= ent_fips_i;
    end
  end

  // Request stays up until the buffer holds a word
  assign ent_req_o = ~rnd_valid_o;

  a_no_ack_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ent_ack_i |-> !rnd_valid_o);

endmodule

`default_nettype wire

// ==== rtl/rv_core_shell.sv ====
/*
 * Shell top level: registers, address remap, enables, faults, entropy
 */
`timescale 1ns/1ps
`default_nettype none
`include "rv_shell_defines.svh"

module rv_core_shell (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  rv_shell_pkg::addr_t        instr_addr_i,
  input  rv_shell_pkg::addr_t        data_addr_i,
  input  rv_shell_pkg::mubi_e        lc_cpu_en_i,
  input  rv_shell_pkg::mubi_e        pwrmgr_cpu_en_i,
  input  logic                       core_sleep_i,
  input  logic                       alert_minor_i,
  input  logic                       alert_major_internal_i,
  input  logic                       alert_major_bus_i,
  input  logic                       double_fault_i,
  input  rv_shell_pkg::addr_t        exc_pc_i,
  input  rv_shell_pkg::addr_t        exc_addr_i,
  input  logic                       nmi_wdog_i,
  input  logic                       nmi_esc_i,
  input  logic                       reg_we_i,
  input  logic                       reg_re_i,
  input  logic [`RV_SHELL_REG_AW-1:0] reg_addr_i,
  input  rv_shell_pkg::addr_t        reg_wdata_i,
  input  logic                       ent_ack_i,
  input  rv_shell_pkg::addr_t        ent_data_i,
  input  logic                       ent_fips_i,
  output rv_shell_pkg::addr_t        instr_addr_o,
  output rv_shell_pkg::addr_t        data_addr_o,
  output logic                       fetch_enable_o,
  output logic                       core_sleeping_o,
  output logic                       irq_nm_o,
  output logic                       prev_valid_o,
  output rv_shell_pkg::addr_t        prev_exc_pc_o,
  output rv_shell_pkg::addr_t        prev_exc_addr_o,
  output rv_shell_pkg::addr_t        reg_rdata_o,
  output logic                       ent_req_o
);
  import rv_shell_pkg::*;

  // Region configuration per bus
  logic  [`RV_SHELL_NUM_REGIONS-1:0] ibus_en;
  logic  [`RV_SHELL_NUM_REGIONS-1:0] dbus_en;
  addr_t [`RV_SHELL_NUM_REGIONS-1:0] ibus_match;
  addr_t [`RV_SHELL_NUM_REGIONS-1:0] ibus_remap;
  addr_t [`RV_SHELL_NUM_REGIONS-1:0] dbus_match;
  addr_t [`RV_SHELL_NUM_REGIONS-1:0] dbus_remap;

  // Grouped core events
  logic fatal_intg;
  logic fatal_core;
  logic recov_core;

  // Entropy buffer state
  addr_t rnd_data;
  logic  rnd_valid;
  logic  rnd_fips;
  logic  rnd_clear;

  cfg_regs u_cfg_regs (
    .clk_i,
    .rst_ni,
    .reg_we_i,
    .reg_re_i,
    .reg_addr_i,
    .reg_wdata_i,
    .nmi_wdog_i,
    .nmi_esc_i,
    .fatal_intg_i (fatal_intg),
    .fatal_core_i (fatal_core),
    .recov_core_i (recov_core),
    .rnd_data_i   (rnd_data),
    .rnd_valid_i  (rnd_valid),
    .rnd_fips_i   (rnd_fips),
    .reg_rdata_o,
    .ibus_en_o    (ibus_en),
    .ibus_match_o (ibus_match),
    .ibus_remap_o (ibus_remap),
    .dbus_en_o    (dbus_en),
    .dbus_match_o (dbus_match),
    .dbus_remap_o (dbus_remap),
    .irq_nm_o,
    .rnd_clear_o  (rnd_clear)
  );

  addr_remap u_ibus_remap (
    .addr_i         (instr_addr_i),
    .region_en_i    (ibus_en),
    .region_match_i (ibus_match),
    .region_remap_i (ibus_remap),
    .addr_o         (instr_addr_o)
  );

  addr_remap u_dbus_remap (
    .addr_i         (data_addr_i),
    .region_en_i    (dbus_en),
    .region_match_i (dbus_match),
    .region_remap_i (dbus_remap),
    .addr_o         (data_addr_o)
  );

  cpu_enable_ctrl u_cpu_enable_ctrl (
    .clk_i,
    .rst_ni,
    .lc_cpu_en_i,
    .pwrmgr_cpu_en_i,
    .fatal_core_i (fatal_core),
    .core_sleep_i,
    .fetch_enable_o,
    .core_sleeping_o
  );

  fault_tracker u_fault_tracker (
    .clk_i,
    .rst_ni,
    .alert_minor_i,
    .alert_major_internal_i,
    .alert_major_bus_i,
    .double_fault_i,
    .exc_pc_i,
    .exc_addr_i,
    .fatal_intg_o (fatal_intg),
    .fatal_core_o (fatal_core),
    .recov_core_o (recov_core),
    .prev_valid_o,
    .prev_exc_pc_o,
    .prev_exc_addr_o
  );

  rnd_buffer u_rnd_buffer (
    .clk_i,
    .rst_ni,
    .rnd_clear_i (rnd_clear),
    .ent_ack_i,
    .ent_data_i,
    .ent_fips_i,
    .ent_req_o,
    .rnd_data_o  (rnd_data),
    .rnd_valid_o (rnd_valid),
    .rnd_fips_o  (rnd_fips)
  );

endmodule

`default_nettype wire

// ==== bench/tb_clk_gen.sv ====
/*
 * Free-running testbench clock
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PeriodNs = 8
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== bench/tb_rv_core_shell.sv ====
/*
 * Core shell testbench with random stimulus, reference model,
 * entropy source model, checks and watchdog
 */
`timescale 1ns/1ps
`default_nettype none
`include "rv_shell_defines.svh"

module tb_rv_core_shell;
  import rv_shell_pkg::*;

  localparam int ResetCycles = 16;
  // Upper bounds per test in clock cycles
  localparam int ReadbackCycles = 280;
  localparam int RemapCycles    = 300;
  localparam int FetchCycles    = 210;
  localparam int NmiCycles      = 200;
  localparam int EntropyCycles  = 400;
  localparam int FatalCycles    = 260;
  localparam int WatchdogCycles = (ResetCycles + ReadbackCycles + RemapCycles + FetchCycles +
                                   NmiCycles + EntropyCycles + FatalCycles) * 2;

  logic clk_i;
  logic rst_ni;
  addr_t instr_addr_i, data_addr_i, exc_pc_i, exc_addr_i, reg_wdata_i, ent_data_i;
  mubi_e lc_cpu_en_i, pwrmgr_cpu_en_i;
  logic core_sleep_i, alert_minor_i, alert_major_internal_i, alert_major_bus_i;
  logic double_fault_i, nmi_wdog_i, nmi_esc_i, reg_we_i, reg_re_i, ent_ack_i, ent_fips_i;
  logic [`RV_SHELL_REG_AW-1:0] reg_addr_i;
  addr_t instr_addr_o, data_addr_o, prev_exc_pc_o, prev_exc_addr_o, reg_rdata_o;
  logic fetch_enable_o, core_sleeping_o, irq_nm_o, prev_valid_o, ent_req_o;

  // Reference model state
  logic [31:0] m_reg [256];
  logic [1:0]  m_nmi_state;
  logic [2:0]  m_err;
  logic        m_local_on;
  logic [31:0] m_rnd_data;
  logic        m_rnd_valid;
  logic        m_rnd_fips;
  int          region_k [2][2];
  logic [7:0]  cfg_addrs [11] = '{8'h00, 8'h14, 8'h18, 8'h40, 8'h44, 8'h60, 8'h64,
                                  8'h80, 8'h84, 8'hA0, 8'hA4};
  logic [31:0] rng_state = 32'd46;
  int          errors = 0;

  tb_clk_gen #(.PeriodNs(8)) u_clk_gen (.clk_o(clk_i));

  rv_core_shell dut0 (.*);

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // Mask of the n lowest bits
  function automatic logic [31:0] lo_mask(input int n);
    if (n >= 32) begin
      return '1;
    end
    return (32'd1 << n) - 32'd1;
  endfunction

  function automatic logic is_config(input logic [7:0] addr);
    logic found;
    found = 1'b0;
    foreach (cfg_addrs[i]) begin
      if (cfg_addrs[i] == addr) found = 1'b1;
    end
    return found;
  endfunction

  function automatic logic [7:0] match_off(input int b, input int i);
    logic [7:0] off;
    off = (b == 0) ? 8'h40 : 8'h80;
    return off + ((i == 0) ? 8'h00 : 8'h04);
  endfunction

  function automatic void reset_model();
    foreach (m_reg[i]) m_reg[i] = '0;
    m_nmi_state = '0;
    m_err = '0;
    m_local_on = 1'b1;
  endfunction

  function automatic logic [31:0] model_read(input logic [7:0] addr);
    logic [31:0] v;
    case (addr)
      8'h04:   v = {30'd0, m_nmi_state};
      8'h08:   v = {29'd0, m_err};
      8'h0C:   v = m_rnd_data;
      8'h10:   v = {30'd0, m_rnd_fips, m_rnd_valid};
      default: v = m_reg[addr];
    endcase
    return v;
  endfunction

  // Lowest enabled region whose high bits match wins
  function automatic logic [31:0] remap_model(input logic [31:0] addr, input int b);
    logic [31:0] res;
    logic [31:0] match;
    logic [31:0] keep;
    logic [1:0]  en;
    logic        hit;
    int          k;
    res = addr;
    hit = 1'b0;
    en = m_reg[(b == 0) ? 8'h14 : 8'h18][1:0];
    for (int i = 0; i < 2; i++) begin
      match = m_reg[match_off(b, i)];
      k = 0;
      while (k < 32 && match[k]) k++;
      keep = lo_mask(k + 1);
      if (!hit && en[i] && ((addr & ~keep) == (match & ~keep))) begin
        hit = 1'b1;
        res = (m_reg[match_off(b, i) + 8'h20] & ~keep) | (addr & keep);
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] pick_addr(input int b);
    logic [31:0] r;
    logic [31:0] keep;
    int          i;
    r = rand32();
    i = r[0];
    keep = lo_mask(region_k[b][i] + 1);
    if (r[3:2] == 2'd0) begin
      return rand32();
    end
    return (m_reg[match_off(b, i)] & ~keep) | (rand32() & keep);
  endfunction

  function automatic mubi_e pick_mubi();
    logic [31:0] r;
    mubi_e       v;
    r = rand32();
    case (r[1:0])
      2'd2:    v = MUBI_OFF;
      2'd3:    v = mubi_e'(r[7:4]);
      default: v = MUBI_ON;
    endcase
    return v;
  endfunction

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    reset_model();
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk_i);
    reg_we_i = 1'b1;
    reg_addr_i = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_we_i = 1'b0;
    if (is_config(addr)) begin
      m_reg[addr] = (addr == 8'h00 || addr == 8'h14 || addr == 8'h18) ? (data & 32'h3) : data;
    end else if (addr == 8'h04) begin
      m_nmi_state = m_nmi_state & ~data[1:0];
    end else if (addr == 8'h08) begin
      m_err = m_err & ~data[2:0];
    end
  endtask

  task automatic read_expect(input logic [7:0] addr);
    logic [31:0] exp;
    @(negedge clk_i);
    reg_re_i = 1'b1;
    reg_addr_i = addr;
    #1;
    exp = model_read(addr);
    check_value($sformatf("read of offset 0x%02h", addr), reg_rdata_o, exp);
    @(negedge clk_i);
    reg_re_i = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reg_readback();
    logic [31:0] r;
    for (int n = 0; n < 3; n++) begin
      foreach (cfg_addrs[i]) reg_write(cfg_addrs[i], rand32());
      foreach (cfg_addrs[i]) read_expect(cfg_addrs[i]);
    end
    // Unmapped offsets ignore writes and read zero
    for (int n = 0; n < 24; n++) begin
      r = rand32();
      if (!is_config(r[7:0]) && r[7:0] != 8'h04 && r[7:0] != 8'h08 &&
          r[7:0] != 8'h0C && r[7:0] != 8'h10) begin
        reg_write(r[7:0], rand32());
        read_expect(r[7:0]);
      end
    end
    foreach (cfg_addrs[i]) read_expect(cfg_addrs[i]);
  endtask

  task automatic test_addr_remap();
    logic [31:0] base;
    int          k;
    for (int r = 0; r < 4; r++) begin
      for (int b = 0; b < 2; b++) begin
        for (int i = 0; i < 2; i++) begin
          // Reusing the base nests region 1 inside or around region 0
          if (i == 0 || rand32() % 2 == 0) base = rand32();
          k = rand32() % 16;
          region_k[b][i] = k;
          reg_write(match_off(b, i), (base & ~lo_mask(k + 1)) | lo_mask(k));
          reg_write(match_off(b, i) + 8'h20, rand32());
        end
        reg_write((b == 0) ? 8'h14 : 8'h18, rand32());
      end
      for (int n = 0; n < 50; n++) begin
        @(negedge clk_i);
        instr_addr_i = pick_addr(0);
        data_addr_i = pick_addr(1);
        #1;
        check_value("instr_addr_o", instr_addr_o, remap_model(instr_addr_i, 0));
        check_value("data_addr_o", data_addr_o, remap_model(data_addr_i, 1));
      end
    end
  endtask

  task automatic test_fetch_enable();
    logic [3:0]  lc_h [2];
    logic [3:0]  pwr_h [2];
    logic        sleep_h;
    logic [31:0] r;
    @(negedge clk_i);
    lc_cpu_en_i = MUBI_ON;
    pwrmgr_cpu_en_i = MUBI_ON;
    core_sleep_i = 1'b0;
    repeat (2) @(negedge clk_i);
    lc_h = '{4'b1010, 4'b1010};
    pwr_h = '{4'b1010, 4'b1010};
    sleep_h = 1'b0;
    for (int n = 0; n < 200; n++) begin
      @(negedge clk_i);
      check_value("fetch_enable_o", fetch_enable_o,
                  lc_h[1] == 4'b1010 && pwr_h[1] == 4'b1010 && m_local_on);
      check_value("core_sleeping_o", core_sleeping_o, sleep_h);
      r = rand32();
      lc_cpu_en_i = pick_mubi();
      pwrmgr_cpu_en_i = pick_mubi();
      core_sleep_i = r[9];
      lc_h[1] = lc_h[0];
      pwr_h[1] = pwr_h[0];
      lc_h[0] = lc_cpu_en_i;
      pwr_h[0] = pwrmgr_cpu_en_i;
      sleep_h = core_sleep_i;
    end
  endtask

  task automatic test_nmi();
    logic [31:0] r;
    logic [1:0]  pulse;
    for (int n = 0; n < 12; n++) begin
      r = rand32();
      reg_write(8'h00, {30'd0, r[1:0]});
      pulse = (r[5:4] == 2'd0) ? 2'b11 : r[5:4];
      @(negedge clk_i);
      nmi_esc_i = pulse[0];
      nmi_wdog_i = pulse[1];
      @(negedge clk_i);
      nmi_esc_i = 1'b0;
      nmi_wdog_i = 1'b0;
      // Two edges in and still inside the synchroniser
      @(negedge clk_i);
      reg_re_i = 1'b1;
      reg_addr_i = 8'h04;
      #1;
      check_value("NMI_STATE two edges after pulse", reg_rdata_o, {30'd0, m_nmi_state});
      @(negedge clk_i);
      m_nmi_state = m_nmi_state | pulse;
      #1;
      check_value("NMI_STATE three edges after pulse", reg_rdata_o, {30'd0, m_nmi_state});
      check_value("irq_nm_o", irq_nm_o, |(m_nmi_state & m_reg[0][1:0]));
      @(negedge clk_i);
      reg_re_i = 1'b0;
      reg_write(8'h04, rand32());
      check_value("irq_nm_o after clear", irq_nm_o, |(m_nmi_state & m_reg[0][1:0]));
      read_expect(8'h04);
    end
  endtask

  task automatic test_entropy();
    int polls;
    for (int n = 0; n < 16; n++) begin
      polls = 0;
      do begin
        read_expect(8'h10);
        polls++;
      end while (ent_req_o && polls < 10);
      assert (!ent_req_o) else begin
        errors++;
        $display("Error at %0t ns: the entropy buffer never filled after a read", $time);
      end
      read_expect(8'h0C);
      check_value("ent_req_o after data read", ent_req_o, 1'b1);
      read_expect(8'h10);
    end
  endtask

  task automatic test_fatal_latch();
    logic [31:0] pc;
    logic [31:0] ea;
    logic        fatal;
    for (int ev = 0; ev < 4; ev++) begin
      @(negedge clk_i);
      lc_cpu_en_i = MUBI_ON;
      pwrmgr_cpu_en_i = MUBI_ON;
      repeat (3) @(negedge clk_i);
      check_value("fetch_enable_o before event", fetch_enable_o, 1'b1);
      pc = rand32();
      ea = rand32();
      fatal = (ev >= 2);
      alert_minor_i = (ev == 0);
      alert_major_bus_i = (ev == 1);
      alert_major_internal_i = (ev == 2);
      double_fault_i = (ev == 3);
      exc_pc_i = pc;
      exc_addr_i = ea;
      @(negedge clk_i);
      {alert_minor_i, alert_major_bus_i, alert_major_internal_i, double_fault_i} = '0;
      exc_pc_i = rand32();
      exc_addr_i = rand32();
      m_err[(ev == 0) ? 2 : (ev == 1) ? 0 : 1] = 1'b1;
      if (fatal) m_local_on = 1'b0;
      check_value("fetch_enable_o one cycle after event", fetch_enable_o, m_local_on);
      if (ev == 3) begin
        check_value("prev_valid_o", prev_valid_o, 1'b1);
        check_value("prev_exc_pc_o", prev_exc_pc_o, pc);
        check_value("prev_exc_addr_o", prev_exc_addr_o, ea);
      end
      // Fetch stays off whatever the enables do
      for (int n = 0; n < 10 && fatal; n++) begin
        @(negedge clk_i);
        lc_cpu_en_i = pick_mubi();
        pwrmgr_cpu_en_i = pick_mubi();
        check_value("fetch_enable_o after fatal", fetch_enable_o, 1'b0);
      end
      read_expect(8'h08);
      reg_write(8'h08, 32'h7);
      read_expect(8'h08);
      if (ev == 3) begin
        pc = rand32();
        ea = rand32();
        @(negedge clk_i);
        double_fault_i = 1'b1;
        exc_pc_i = pc;
        exc_addr_i = ea;
        @(negedge clk_i);
        double_fault_i = 1'b0;
        m_err[1] = 1'b1;
        check_value("prev_exc_pc_o overwritten", prev_exc_pc_o, pc);
        check_value("prev_exc_addr_o overwritten", prev_exc_addr_o, ea);
      end
      if (fatal) begin
        apply_reset();
        check_value("prev_valid_o after reset", prev_valid_o, 1'b0);
        check_value("fetch_enable_o after reset", fetch_enable_o, 1'b0);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Entropy source, buffer model and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin : entropy_source
    logic [31:0] es;
    int unsigned delay;
    es = ~32'd46;
    ent_ack_i = 1'b0;
    ent_data_i = '0;
    ent_fips_i = 1'b0;
    forever begin
      @(negedge clk_i);
      ent_ack_i = 1'b0;
      if (rst_ni && ent_req_o) begin
        es = xorshift32(es);
        delay = es % 8 + 1;
        repeat (delay) @(negedge clk_i);
        if (rst_ni && ent_req_o) begin
          es = xorshift32(es);
          ent_data_i = es;
          ent_fips_i = es[3];
          ent_ack_i = 1'b1;
        end
      end
    end
  end

  // Read of RND_DATA wins over an ack in the same cycle
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_rnd_valid <= 1'b0;
      m_rnd_data  <= '0;
      m_rnd_fips  <= 1'b0;
    end else if (reg_re_i && reg_addr_i == 8'h0C) begin
      m_rnd_valid <= 1'b0;
      m_rnd_data  <= '0;
      m_rnd_fips  <= 1'b0;
    end else if (ent_ack_i) begin
      m_rnd_valid <= 1'b1;
      m_rnd_data  <= ent_data_i;
      m_rnd_fips  <= ent_fips_i;
    end
  end

  initial begin : req_monitor
    forever begin
      @(negedge clk_i);
      #1;
      if (rst_ni) check_value("ent_req_o", ent_req_o, !m_rnd_valid);
    end
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin : main
    rst_ni = 1'b0;
    {instr_addr_i, data_addr_i, exc_pc_i, exc_addr_i, reg_wdata_i} = '0;
    lc_cpu_en_i = MUBI_OFF;
    pwrmgr_cpu_en_i = MUBI_OFF;
    {core_sleep_i, alert_minor_i, alert_major_internal_i, alert_major_bus_i} = '0;
    {double_fault_i, nmi_wdog_i, nmi_esc_i, reg_we_i, reg_re_i} = '0;
    reg_addr_i = '0;
    apply_reset();
    test_reg_readback();
    test_addr_remap();
    test_fetch_enable();
    test_nmi();
    test_entropy();
    test_fatal_latch();
    $display("Tests finished with %0d errors", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/rv_shell_pkg.sv
rtl/addr_remap.sv
cfg_regs/cfg_regs.sv
rtl/cpu_enable_ctrl.sv
rtl/fault_tracker.sv
rtl/rnd_buffer.sv
rtl/rv_core_shell.sv
bench/tb_clk_gen.sv
bench/tb_rv_core_shell.sv
